/* bench/carrierLoopTb.sv */
// Carrier loop testbench
`timescale 1ns/1ps
`default_nettype none

`include "loop_defines.svh"

module carrierLoopTb
    import loopPkg::*;
();

    localparam int NUM_SAMPLES = 50;

    logic                      clk;
    logic                      reset;
    logic                      clkEn;
    logic signed [`ERR_W-1:0]  error;
    logic                      wbCyc;
    logic                      wbStb;
    logic                      wbWe;
    logic [`ADDR_W-1:0]        wbAdr;
    logic [`DATA_W-1:0]        wbDatW;
    logic [3:0]                wbSel;
    logic [`DATA_W-1:0]        wbDatR;
    logic                      wbAck;
    logic signed [`DATA_W-1:0] loopFreq;
    logic                      freqValid;
    logic                      satPos;
    logic                      satNeg;
    lockState_t                lockStatus;

    // bench copies of the register contents
    logic [31:0]        ctrlShadow;
    logic [31:0]        gainShadow;
    logic [31:0]        limitShadow;
    logic [31:0]        lockShadow;
    logic signed [31:0] modelAcc;
    lockState_t         modelLock;
    int                 modelCount;
    logic signed [31:0] expFreq[$];
    logic               expPos[$];
    logic               expNeg[$];
    logic signed [31:0] lastFreq;
    integer             seed;
    string              testName;

    carrierLoop dut_i (
        .clk(clk), .reset(reset), .clkEn(clkEn), .error(error),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck),
        .loopFreq(loopFreq), .freqValid(freqValid),
        .satPos(satPos), .satNeg(satNeg), .lockStatus(lockStatus)
    );

    always #10 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic signed [31:0] exp,
                             input logic signed [31:0] act);
        if (exp !== act) begin
            failRun($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            failRun($sformatf("mismatch %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic checkLock(input string name, input lockState_t exp, input lockState_t act);
        if (exp !== act) begin
            failRun($sformatf("mismatch %s expected %s actual %s",
                              name, exp.name(), act.name()));
        end
    endtask

    function automatic logic [31:0] mergeWord(input logic [31:0] oldWord,
                                              input logic [31:0] newWord,
                                              input logic [3:0] sel);
        logic [31:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) result[8*i +: 8] = newWord[8*i +: 8];
        end
        return result;
    endfunction

    function automatic logic signed [11:0] adjustError(input logic signed [11:0] err,
                                                       input logic inv, input logic zero);
        if (zero) return 12'sd0;
        if (inv) return -err;
        return err;
    endfunction

    // exponent 11 is unity, 0 disables the path
    function automatic logic signed [31:0] powerGain(input logic signed [11:0] err,
                                                     input logic [4:0] expo);
        longint wide;
        int     e;
        wide = err;
        e = int'(expo);
        if (e == 0) return 32'sd0;
        if (e >= 11) wide = wide <<< (e - 11);
        else wide = wide >>> (11 - e);
        return wide[31:0];
    endfunction

    // expected output, updates the model accumulator
    function automatic logic signed [31:0] refModel(
        input logic signed [11:0] err, input logic inv, input logic zero,
        input logic [4:0] leadE, input logic [4:0] lagE, input logic signed [31:0] lim,
        inout logic signed [31:0] acc, output logic sPos, output logic sNeg);
        logic signed [11:0] adj;
        logic signed [31:0] leadT;
        logic signed [31:0] lagT;
        longint             total;
        adj = adjustError(err, inv, zero);
        leadT = powerGain(adj, leadE);
        lagT = powerGain(adj, lagE);
        total = longint'(acc) + longint'(lagT);
        sPos = 1'b0;
        sNeg = 1'b0;
        if (total > longint'(lim)) begin
            acc = lim;
            sPos = 1'b1;
        end else if (total < -longint'(lim)) begin
            acc = -lim;
            sNeg = 1'b1;
        end else begin
            acc = total[31:0];
        end
        return acc + leadT;
    endfunction

    task automatic lockModelStep(input logic signed [11:0] adj);
        int mag;
        bit inThresh;
        mag = (adj < 0) ? -int'(adj) : int'(adj);
        inThresh = mag <= int'(lockShadow[27:16]);
        if (modelLock == LOCK_ACQUIRE) begin
            if (!inThresh) modelCount = 0;
            else if (lockShadow[15:0] != 0 && modelCount + 1 >= int'(lockShadow[15:0])) begin
                modelLock = LOCK_HELD;
                modelCount = 0;
            end else modelCount++;
        end else if (!inThresh) begin
            modelLock = LOCK_ACQUIRE;
            modelCount = 0;
        end
    endtask

    task automatic wbWrite(input regAddr_t a, input logic [31:0] d, input logic [3:0] s);
        int waitCycles;
        @(negedge clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = a;
        wbDatW = d;
        wbSel = s;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > 20) failRun("no wishbone ack on a write");
        end while (!wbAck);
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        case (a)
            REG_CTRL:  ctrlShadow = mergeWord(ctrlShadow, d, s) & 32'hFFFF_FFFB;
            REG_GAIN:  gainShadow = mergeWord(gainShadow, d, s);
            REG_LIMIT: limitShadow = mergeWord(limitShadow, d, s);
            REG_LOCK:  lockShadow = mergeWord(lockShadow, d, s);
            default: ;
        endcase
    endtask

    task automatic wbRead(input regAddr_t a, output logic [31:0] d);
        int waitCycles;
        @(negedge clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = a;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > 20) failRun("no wishbone ack on a read");
        end while (!wbAck);
        d = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic clearAccumulator();
        wbWrite(REG_CTRL, ctrlShadow | 32'h4, 4'h1);
        modelAcc = 32'sd0;
    endtask

    // one sample, then settle until the output and lock state are done
    task automatic issueSample(input logic signed [11:0] e);
        logic signed [31:0] f;
        logic               p;
        logic               n;
        f = refModel(e, ctrlShadow[`CTRL_INVERT], ctrlShadow[`CTRL_ZERO], gainShadow[4:0],
                     gainShadow[12:8], limitShadow, modelAcc, p, n);
        expFreq.push_back(f);
        expPos.push_back(p);
        expNeg.push_back(n);
        lockModelStep(adjustError(e, ctrlShadow[`CTRL_INVERT], ctrlShadow[`CTRL_ZERO]));
        @(negedge clk);
        clkEn = 1'b1;
        error = e;
        @(negedge clk);
        clkEn = 1'b0;
        repeat (5) @(negedge clk);
        checkLock({testName, " lock"}, modelLock, lockStatus);
    endtask

    always @(negedge clk) begin
        if (!reset && freqValid) begin
            if (expFreq.size() == 0) begin
                failRun("freqValid pulsed with no sample outstanding");
            end else begin
                checkWord({testName, " loopFreq"}, expFreq.pop_front(), loopFreq);
                checkFlag({testName, " satPos"}, expPos.pop_front(), satPos);
                checkFlag({testName, " satNeg"}, expNeg.pop_front(), satNeg);
                lastFreq = loopFreq;
            end
        end
    end

    initial begin
        repeat (NUM_SAMPLES * 10 + 2000) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0]        d;
        logic [31:0]        r;
        logic [4:0]         leadE;
        logic [4:0]         lagE;
        clk = 1'b0;
        reset = 1'b1;
        clkEn = 1'b0;
        error = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        wbSel = '0;
        {ctrlShadow, gainShadow, limitShadow, lockShadow} = '0;
        modelAcc = 32'sd0;
        modelLock = LOCK_ACQUIRE;
        modelCount = 0;
        lastFreq = 32'sd0;
        seed = 32'he709;
        testName = "reset";
        repeat (5) @(negedge clk);
        reset = 1'b0;

        testName = "registers";
        wbWrite(REG_GAIN, 32'hAABBCCDD, 4'hF);
        wbWrite(REG_GAIN, 32'h11223344, 4'b0101);
        wbRead(REG_GAIN, d);
        checkWord(testName, 32'hAA22CC44, d);
        wbWrite(REG_LIMIT, 32'h12345678, 4'hF);
        wbWrite(REG_LIMIT, 32'hFFFF0000, 4'b1100);
        wbRead(REG_LIMIT, d);
        checkWord(testName, 32'hFFFF5678, d);
        wbWrite(REG_LOCK, 32'h0ABC1234, 4'b0011);
        wbWrite(REG_LOCK, 32'h0ABC0000, 4'b1000);
        wbRead(REG_LOCK, d);
        checkWord(testName, 32'h0A001234, d);
        wbWrite(REG_CTRL, 32'h7, 4'h1);
        wbRead(REG_CTRL, d);
        checkWord(testName, 32'h3, d);  // clear bit never stored
        wbWrite(REG_CTRL, 32'h0, 4'hF);
        wbWrite(REG_STATUS, 32'hFFFFFFFF, 4'hF);
        wbRead(REG_STATUS, d);
        checkWord(testName, 32'h0, d);
        wbWrite(REG_ACCUM, 32'h1234, 4'hF);
        wbRead(REG_ACCUM, d);
        checkWord(testName, 32'h0, d);
        // writable registers untouched by the read-only writes
        wbRead(REG_CTRL, d);
        checkWord({testName, " unchanged"}, 32'h0, d);
        wbRead(REG_GAIN, d);
        checkWord({testName, " unchanged"}, 32'hAA22CC44, d);
        wbRead(REG_LIMIT, d);
        checkWord({testName, " unchanged"}, 32'hFFFF5678, d);
        wbRead(REG_LOCK, d);
        checkWord({testName, " unchanged"}, 32'h0A001234, d);
        wbRead(regAddr_t'(3'd6), d);
        checkWord(testName, 32'h0, d);
        wbWrite(REG_LOCK, 32'h0, 4'hF);

        testName = "gains";
        wbWrite(REG_LIMIT, 32'h40000000, 4'hF);
        clearAccumulator();
        for (int i = 0; i < 30; i++) begin
            r = $random(seed);
            leadE = r[20:16];
            lagE = r[28:24];
            case (i)  // fixed corners first, unity and its neighbours
                0: {leadE, lagE} = {5'd0, 5'd11};
                1: {leadE, lagE} = {5'd11, 5'd0};
                2: {leadE, lagE} = {5'd10, 5'd12};
                3: {leadE, lagE} = {5'd1, 5'd31};
                4: {leadE, lagE} = {5'd31, 5'd1};
                default: ;
            endcase
            wbWrite(REG_GAIN, {19'd0, lagE, 3'd0, leadE}, 4'hF);
            issueSample(r[11:0]);
        end

        testName = "saturation";
        clearAccumulator();
        wbWrite(REG_LIMIT, 32'd1000, 4'hF);
        wbWrite(REG_GAIN, {19'd0, 5'd15, 3'd0, 5'd0}, 4'hF);
        repeat (3) issueSample(12'sd100);
        wbRead(REG_ACCUM, d);
        checkWord(testName, 32'sd1000, d);
        wbRead(REG_STATUS, d);
        checkFlag({testName, " status satPos"}, 1'b1, d[`STAT_SATPOS]);
        repeat (3) issueSample(-12'sd100);
        wbRead(REG_ACCUM, d);
        checkWord(testName, -32'sd1000, d);
        wbRead(REG_STATUS, d);
        checkFlag({testName, " status satNeg"}, 1'b1, d[`STAT_SATNEG]);
        issueSample(12'sd10);  // back inside the limit
        wbRead(REG_STATUS, d);
        checkFlag({testName, " status satPos"}, 1'b0, d[`STAT_SATPOS]);
        checkFlag({testName, " status satNeg"}, 1'b0, d[`STAT_SATNEG]);

        testName = "error controls";
        wbWrite(REG_LIMIT, 32'h40000000, 4'hF);
        wbWrite(REG_GAIN, {19'd0, 5'd11, 3'd0, 5'd11}, 4'hF);
        wbWrite(REG_CTRL, 32'h0, 4'hF);
        clearAccumulator();
        issueSample(12'sd50);
        checkWord({testName, " normal"}, 32'sd100, lastFreq);  // unity lead plus unity lag
        clearAccumulator();
        wbWrite(REG_CTRL, 32'h1, 4'hF);
        issueSample(12'sd50);
        checkWord({testName, " invert"}, -32'sd100, lastFreq);
        wbWrite(REG_CTRL, 32'h2, 4'hF);
        wbRead(REG_ACCUM, d);
        checkWord({testName, " accum before zero"}, -32'sd50, d);
        issueSample(12'sd300);
        checkWord({testName, " zero output"}, -32'sd50, lastFreq);
        wbRead(REG_ACCUM, d);
        checkWord({testName, " zero accum"}, -32'sd50, d);
        clearAccumulator();
        wbRead(REG_ACCUM, d);
        checkWord({testName, " clear"}, 32'sd0, d);

        testName = "lock";
        wbWrite(REG_CTRL, 32'h0, 4'hF);
        wbWrite(REG_GAIN, 32'h0, 4'hF);
        wbWrite(REG_LOCK, {4'd0, 12'd20, 16'd4}, 4'hF);
        issueSample(12'sd500);  // start from an empty count
        issueSample(12'sd5);
        issueSample(-12'sd20);
        issueSample(12'sd300);  // restarts the count
        issueSample(12'sd7);
        issueSample(12'sd0);
        issueSample(-12'sd3);
        checkLock({testName, " before count"}, LOCK_ACQUIRE, lockStatus);
        issueSample(12'sd15);
        checkLock({testName, " acquired"}, LOCK_HELD, lockStatus);
        issueSample(-12'sd400);
        checkLock({testName, " dropped"}, LOCK_ACQUIRE, lockStatus);

        repeat (10) @(negedge clk);
        if (expFreq.size() != 0) begin
            failRun("freqValid pulses missing at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.sh */
#!/bin/bash
# Compile and run the carrier loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f files.f --top-module carrierLoopTb \
    --Mdir obj_dir -o carrierLoopSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/carrierLoopSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

grep -q "^TEST RESULT: PASS$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

/* files.f */
+incdir+rtl
rtl/loopPkg.sv
rtl/loopRegs.sv
rtl/loopFilter.sv
rtl/lockDetector.sv
rtl/carrierLoop.sv
bench/carrierLoopTb.sv

/* rtl/carrierLoop.sv */
// Carrier recovery loop top
`timescale 1ns/1ps
`default_nettype none

`include "loop_defines.svh"

module carrierLoop
    import loopPkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic signed [`ERR_W-1:0]    error,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`ADDR_W-1:0]          wbAdr,
    input  logic [`DATA_W-1:0]          wbDatW,
    input  logic [3:0]                  wbSel,
    output logic [`DATA_W-1:0]          wbDatR,
    output logic                        wbAck,
    output logic signed [`DATA_W-1:0]   loopFreq,
    output logic                        freqValid,
    output logic                        satPos,
    output logic                        satNeg,
    output lockState_t                  lockStatus
);

    // register block to filter
    logic                       invertError;
    logic                       zeroError;
    logic                       clearAccum;
    logic [`GAIN_W-1:0]         leadExp;
    logic [`GAIN_W-1:0]         lagExp;
    logic signed [`DATA_W-1:0]  limit;
    logic signed [`DATA_W-1:0]  lagAccum;
    // filter and registers to lock detector
    logic signed [`ERR_W-1:0]   loopError;
    logic                       errorValid;
    logic [`CNT_W-1:0]          lockCount;
    logic [`ERR_W-1:0]          syncThreshold;

    loopRegs regs (
        .clk(clk), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR), .wbAck(wbAck),
        .lagAccum(lagAccum), .satPos(satPos), .satNeg(satNeg), .lockStatus(lockStatus),
        .invertError(invertError), .zeroError(zeroError), .clearAccum(clearAccum),
        .leadExp(leadExp), .lagExp(lagExp), .limit(limit),
        .lockCount(lockCount), .syncThreshold(syncThreshold)
    );

    loopFilter filter (
        .clk(clk), .reset(reset), .clkEn(clkEn), .error(error),
        .invertError(invertError), .zeroError(zeroError), .clearAccum(clearAccum),
        .leadExp(leadExp), .lagExp(lagExp), .limit(limit),
        .loopFreq(loopFreq), .freqValid(freqValid), .lagAccum(lagAccum),
        .satPos(satPos), .satNeg(satNeg),
        .loopError(loopError), .errorValid(errorValid)
    );

    lockDetector lockDet (
        .clk(clk), .reset(reset),
        .loopError(loopError), .errorValid(errorValid),
        .lockCount(lockCount), .syncThreshold(syncThreshold),
        .lockStatus(lockStatus)
    );

endmodule

`default_nettype wire

/* rtl/lockDetector.sv */
// Loop lock detector
`timescale 1ns/1ps
`default_nettype none

`include "loop_defines.svh"

module lockDetector
    import loopPkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic signed [`ERR_W-1:0]    loopError,
    input  logic                        errorValid,
    input  logic [`CNT_W-1:0]           lockCount,
    input  logic [`ERR_W-1:0]           syncThreshold,
    output lockState_t                  lockStatus
);

    logic signed [`ERR_W:0] errWide;
    logic [`ERR_W:0]        errMag;     // holds 2048 for the most negative error
    logic                   inRange;
    logic [`CNT_W-1:0]      count;      // consecutive good samples
    logic [`CNT_W:0]        countNext;
    logic                   reached;

    assign errWide   = loopError;
    assign errMag    = errWide[`ERR_W] ? -errWide : errWide;
    assign inRange   = errMag <= {1'b0, syncThreshold};
    assign countNext = {1'b0, count} + 1'b1;
    assign reached   = (lockCount != '0) && (countNext >= {1'b0, lockCount});

    always_ff @(posedge clk) begin
        if (reset) begin
            lockStatus <= LOCK_ACQUIRE;
            count      <= '0;
        end else if (errorValid) begin
            case (lockStatus)
                LOCK_ACQUIRE: begin
                    if (!inRange) begin
                        count <= '0;  // run broken, start over
                    end else if (reached) begin
                        lockStatus <= LOCK_HELD;
                        count      <= '0;
                    end else begin
                        count <= countNext[`CNT_W-1:0];
                    end
                end
                LOCK_HELD: begin
                    // a single bad sample drops lock
                    if (!inRange) begin
                        lockStatus <= LOCK_ACQUIRE;
                        count      <= '0;
                    end
                end
                default: begin
                    lockStatus <= LOCK_ACQUIRE;
                    count      <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/loopFilter.sv */
// Lead-lag loop filter
`timescale 1ns/1ps
`default_nettype none

`include "loop_defines.svh"

module loopFilter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic signed [`ERR_W-1:0]    error,
    input  logic                        invertError,
    input  logic                        zeroError,
    input  logic                        clearAccum,
    input  logic [`GAIN_W-1:0]          leadExp,
    input  logic [`GAIN_W-1:0]          lagExp,
    input  logic signed [`DATA_W-1:0]   limit,
    output logic signed [`DATA_W-1:0]   loopFreq,
    output logic                        freqValid,
    output logic signed [`DATA_W-1:0]   lagAccum,
    output logic                        satPos,
    output logic                        satNeg,
    output logic signed [`ERR_W-1:0]    loopError,
    output logic                        errorValid
);

    logic [2:0]                 enDly;      // sample enable through the pipe
    logic signed [`DATA_W-1:0]  leadTerm;
    logic signed [`DATA_W-1:0]  lagTerm;
    logic signed [`DATA_W-1:0]  leadDly;    // lines lead up with the accumulator
    logic signed [`DATA_W:0]    sum;        // one guard bit
    logic signed [`DATA_W:0]    upper;
    logic signed [`DATA_W:0]    lower;

    // power-of-two gain, exponent 11 is unity and 0 turns the path off
    function automatic logic signed [`DATA_W-1:0] gainTerm(
        input logic signed [`ERR_W-1:0] err,
        input logic [`GAIN_W-1:0]       expo
    );
        logic signed [`DATA_W-1:0] wide;
        wide = err;  // sign extends
        if (expo == '0) begin
            return '0;
        end
        if (expo >= `UNITY_GAIN) begin
            return wide <<< (expo - `UNITY_GAIN);
        end
        return wide >>> (`UNITY_GAIN - expo);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            enDly     <= '0;
            freqValid <= 1'b0;
        end else begin
            enDly     <= {enDly[1:0], clkEn};
            freqValid <= enDly[2];
        end
    end

    assign errorValid = enDly[0];

    // error adjust, zero wins over invert
    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (zeroError) begin
                loopError <= '0;
            end else if (invertError) begin
                loopError <= -error;
            end else begin
                loopError <= error;
            end
        end
    end

    // gain stage
    always_ff @(posedge clk) begin
        if (enDly[0]) begin
            leadTerm <= gainTerm(loopError, leadExp);
            lagTerm  <= gainTerm(loopError, lagExp);
        end
    end

    assign sum   = {lagAccum[`DATA_W-1], lagAccum} + {lagTerm[`DATA_W-1], lagTerm};
    assign upper = {limit[`DATA_W-1], limit};
    assign lower = -upper;

    // lag accumulator with symmetric clamp
    always_ff @(posedge clk) begin
        if (reset || clearAccum) begin
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (enDly[1]) begin
            if (sum > upper) begin
                lagAccum <= upper[`DATA_W-1:0];
                satPos   <= 1'b1;
                satNeg   <= 1'b0;
            end else if (sum < lower) begin
                lagAccum <= lower[`DATA_W-1:0];
                satPos   <= 1'b0;
                satNeg   <= 1'b1;
            end else begin
                lagAccum <= sum[`DATA_W-1:0];
                satPos   <= 1'b0;
                satNeg   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enDly[1]) begin
            leadDly <= leadTerm;
        end
    end

    // filter output
    always_ff @(posedge clk) begin
        if (enDly[2]) begin
            loopFreq <= lagAccum + leadDly;
        end
    end

endmodule

`default_nettype wire

/* rtl/loopPkg.sv */
// Carrier loop types
`default_nettype none

`include "loop_defines.svh"

package loopPkg;

    // word addresses on the wishbone port
    typedef enum logic [`ADDR_W-1:0] {
        REG_CTRL   = 3'd0,  // invert, zero and clear bits
        REG_GAIN   = 3'd1,  // lead and lag exponents
        REG_LIMIT  = 3'd2,  // symmetric clamp
        REG_LOCK   = 3'd3,  // lock count and threshold
        REG_STATUS = 3'd4,  // read only
        REG_ACCUM  = 3'd5   // read only
    } regAddr_t;

    // lock detector FSM
    typedef enum logic {
        LOCK_ACQUIRE = 1'b0,  // counting in-threshold samples
        LOCK_HELD    = 1'b1
    } lockState_t;

endpackage

`default_nettype wire

/* rtl/loopRegs.sv */
// Loop register block
`timescale 1ns/1ps
`default_nettype none

`include "loop_defines.svh"

module loopRegs
    import loopPkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    // wishbone classic slave
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`ADDR_W-1:0]          wbAdr,
    input  logic [`DATA_W-1:0]          wbDatW,
    input  logic [3:0]                  wbSel,
    output logic [`DATA_W-1:0]          wbDatR,
    output logic                        wbAck,
    // live status from the loop
    input  logic signed [`DATA_W-1:0]   lagAccum,
    input  logic                        satPos,
    input  logic                        satNeg,
    input  logic                        lockStatus,
    // filter and lock settings
    output logic                        invertError,
    output logic                        zeroError,
    output logic                        clearAccum,
    output logic [`GAIN_W-1:0]          leadExp,
    output logic [`GAIN_W-1:0]          lagExp,
    output logic signed [`DATA_W-1:0]   limit,
    output logic [`CNT_W-1:0]           lockCount,
    output logic [`ERR_W-1:0]           syncThreshold
);

    logic [`DATA_W-1:0] ctrlReg;
    logic [`DATA_W-1:0] gainReg;
    logic [`DATA_W-1:0] limitReg;
    logic [`DATA_W-1:0] lockReg;
    logic [`DATA_W-1:0] statusWord;
    regAddr_t           addr;
    logic               access;
    logic               writeEn;

    // byte lane merge for a selected write
    function automatic logic [`DATA_W-1:0] mergeBytes(
        input logic [`DATA_W-1:0] oldWord,
        input logic [`DATA_W-1:0] newWord,
        input logic [3:0]         sel
    );
        logic [`DATA_W-1:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign addr    = regAddr_t'(wbAdr);
    assign access  = wbCyc && wbStb && !wbAck;  // one ack per strobe
    assign writeEn = access && wbWe;

    always_comb begin
        statusWord = '0;
        statusWord[`STAT_LOCK]   = lockStatus;
        statusWord[`STAT_SATPOS] = satPos;
        statusWord[`STAT_SATNEG] = satNeg;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck      <= 1'b0;
            clearAccum <= 1'b0;
            ctrlReg    <= '0;
            gainReg    <= '0;
            limitReg   <= '0;
            lockReg    <= '0;
        end else begin
            wbAck      <= access;
            // clear is a strobe, never stored
            clearAccum <= writeEn && (addr == REG_CTRL) && wbSel[0] && wbDatW[`CTRL_CLEAR];
            if (writeEn) begin
                case (addr)
                    REG_CTRL: begin
                        ctrlReg <= mergeBytes(ctrlReg, wbDatW, wbSel)
                                   & ~(`DATA_W'(1) << `CTRL_CLEAR);
                    end
                    REG_GAIN:  gainReg  <= mergeBytes(gainReg, wbDatW, wbSel);
                    REG_LIMIT: limitReg <= mergeBytes(limitReg, wbDatW, wbSel);
                    REG_LOCK:  lockReg  <= mergeBytes(lockReg, wbDatW, wbSel);
                    default: ;  // status and accum are read only
                endcase
            end
        end
    end

    // read data, valid alongside ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (addr)
                REG_CTRL:   wbDatR <= ctrlReg;
                REG_GAIN:   wbDatR <= gainReg;
                REG_LIMIT:  wbDatR <= limitReg;
                REG_LOCK:   wbDatR <= lockReg;
                REG_STATUS: wbDatR <= statusWord;
                REG_ACCUM:  wbDatR <= lagAccum;
                default:    wbDatR <= '0;
            endcase
        end
    end

    assign invertError   = ctrlReg[`CTRL_INVERT];
    assign zeroError     = ctrlReg[`CTRL_ZERO];
    assign leadExp       = gainReg[`LEAD_LSB +: `GAIN_W];
    assign lagExp        = gainReg[`LAG_LSB +: `GAIN_W];
    assign limit         = $signed(limitReg);
    assign lockCount     = lockReg[`CNT_W-1:0];
    assign syncThreshold = lockReg[`THRESH_LSB +: `ERR_W];

endmodule

`default_nettype wire

/* rtl/loop_defines.svh */
// Carrier loop widths and fields
`ifndef LOOP_DEFINES_SVH
`define LOOP_DEFINES_SVH

`define ERR_W       12    // phase error width
`define DATA_W      32    // bus and accumulator width
`define GAIN_W      5     // gain exponent width
`define UNITY_GAIN  11    // exponent that passes the error unscaled
`define CNT_W       16    // lock count width
`define ADDR_W      3     // wishbone word address width

// control register bits
`define CTRL_INVERT 0
`define CTRL_ZERO   1
`define CTRL_CLEAR  2

// field offsets inside the gain, lock and status words
`define LEAD_LSB    0
`define LAG_LSB     8
`define THRESH_LSB  16
`define STAT_LOCK   0
`define STAT_SATPOS 1
`define STAT_SATNEG 2

`endif
